// ==== src.f ====
+incdir+include
rtl/tcb_pkg.sv
rtl/tcb_delay_line.sv
rtl/tcb_register_response.sv
rtl/tcb_mem_sub.sv
rtl/tcb_subsystem_top.sv
tb/tcb_assertions.sv
tb/tcb_checker.sv
tb/tcb_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the tcb subsystem testbench with verilator
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

# assertion failures must not stop the run early
verilator --binary --timing --assert --timescale 1ns/1ps \
  -f src.f --top-module tcb_tb -o tcb_sim > build.log 2>&1 \
  && ./obj_dir/tcb_sim +verilator+error+limit+1000 > sim.log 2>&1

# the log decides pass or fail
grep -q "^Simulation PASSED$" sim.log \
  && { echo "run passed, see sim.log"; exit 0; } \
  || { echo "run failed, see build.log and sim.log"; exit 1; }

// ==== tb/tcb_tb.sv ====
`timescale 1ns/1ps
`include "tcb_defines.svh"

module tcb_tb;

  import tcb_pkg::*;

  localparam int RESET_CYCLES = 5;
  // one full write per memory word
  localparam int FILL_XFERS = `TCB_MEM_BYTES / `TCB_BEW;
  // upper bound on directed transfers and idles
  localparam int DIRECTED_CYCLES = 40;
  localparam int RANDOM_XFERS = 400;
  localparam int CYCLE_LIMIT = RESET_CYCLES + FILL_XFERS + DIRECTED_CYCLES
                               + RANDOM_XFERS + 50;

  logic man;
  logic reset;
  logic vld;
  logic wen;
  adr_t adr;
  ben_t ben;
  dat_t wdt;
  dat_t rdt;
  logic err;
  int checks;
  int errors;
  int cycles = 0;
  logic done = 1'b0;

  ////////////////////
  // clock and timeout
  ////////////////////

  initial begin
    man = 1'b0;
    forever #2 man = ~man;
  end

  always @(posedge man) begin
    cycles <= cycles + 1;
    if (!done && cycles >= CYCLE_LIMIT) begin
      $display("timeout: stimulus still running after %0d cycles", CYCLE_LIMIT);
      $display("Simulation FAILED");
      $finish;
    end
  end

  ////////////////////
  // DUT, checker, assertions
  ////////////////////

  tcb_subsystem_top dut0 (
    .man   (man),
    .reset (reset),
    .vld   (vld),
    .wen   (wen),
    .adr   (adr),
    .ben   (ben),
    .wdt   (wdt),
    .rdt   (rdt),
    .err   (err)
  );

  tcb_checker chk0 (
    .man    (man),
    .reset  (reset),
    .vld    (vld),
    .wen    (wen),
    .adr    (adr),
    .ben    (ben),
    .wdt    (wdt),
    .rdt    (rdt),
    .err    (err),
    .checks (checks),
    .errors (errors)
  );

  bind tcb_register_response tcb_assertions asrt0 (
    .man     (man),
    .reset   (reset),
    .err     (err),
    .man_err (man_err),
    .rdt     (rdt),
    .rbe_dly (rbe_dly)
  );

  ////////////////////
  // stimulus tasks
  ////////////////////

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge man);
      vld <= 1'b0;
      wen <= 1'b0;
    end
  endtask

  task automatic write_word(input adr_t a, input ben_t b, input dat_t d);
    @(posedge man);
    vld <= 1'b1;
    wen <= 1'b1;
    adr <= a;
    ben <= b;
    wdt <= d;
  endtask

  task automatic read_word(input adr_t a, input ben_t b);
    @(posedge man);
    vld <= 1'b1;
    wen <= 1'b0;
    adr <= a;
    ben <= b;
    // wdt is don't care on reads
    wdt <= $urandom;
  endtask

  // fill value mixes all address bits
  function automatic dat_t fill_word(input adr_t a);
    return a ^ {a[15:0], a[31:16]} ^ 32'h5a3c_96e1;
  endfunction

  ////////////////////
  // main sequence
  ////////////////////

  initial begin
    adr_t r_adr;
    int pick;
    int asrt_fails;
    void'($urandom(32'hc7b7583a));
    reset = 1'b1;
    vld = 1'b0;
    wen = 1'b0;
    adr = '0;
    ben = '0;
    wdt = '0;
    repeat (RESET_CYCLES) @(posedge man);
    reset <= 1'b0;

    // memory has no reset, so give every word a known value
    for (int i = 0; i < FILL_XFERS; i++) begin
      write_word(adr_t'(i * `TCB_BEW), 4'hf, fill_word(adr_t'(i * `TCB_BEW)));
    end

    // full word write then read back
    write_word(32'h40, 4'hf, 32'hdead_beef);
    read_word(32'h40, 4'hf);
    // byte merge into an existing word
    write_word(32'h44, 4'hf, 32'h1122_3344);
    write_word(32'h44, 4'b0101, 32'haabb_ccdd);
    read_word(32'h44, 4'hf);
    idle(2);
    // partial read keeps the upper bytes of rdt
    read_word(32'h40, 4'b0011);
    idle(2);
    // writes and idles leave rdt alone
    write_word(32'h48, 4'hf, 32'h0bad_f00d);
    idle(3);
    // out of range write must not alias into the array
    write_word(adr_t'(`TCB_MEM_BYTES) + 32'h40, 4'hf, 32'hffff_ffff);
    read_word(adr_t'(`TCB_MEM_BYTES) + 32'h40, 4'hf);
    read_word(32'h40, 4'hf);
    idle(3);

    // mixed random traffic, mostly back to back
    for (int i = 0; i < RANDOM_XFERS; i++) begin
      pick = $urandom_range(0, 15);
      if (pick == 0) begin
        idle(1);
      end else begin
        if (pick == 1) begin
          r_adr = adr_t'(`TCB_MEM_BYTES) + adr_t'($urandom_range(0, 65535));
        end else begin
          r_adr = adr_t'($urandom_range(0, `TCB_MEM_BYTES - 1));
        end
        if (pick[0]) begin
          write_word(r_adr, ben_t'($urandom), $urandom);
        end else begin
          read_word(r_adr, ben_t'($urandom));
        end
      end
    end

    // let the last responses come out
    idle(4);
    done = 1'b1;
    asrt_fails = dut0.resp_slice.asrt0.fail_count;
    $display("checks %0d, compare errors %0d, assertion failures %0d",
             checks, errors, asrt_fails);
    if (errors == 0 && asrt_fails == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== tb/tcb_checker.sv ====
`timescale 1ns/1ps
`include "tcb_defines.svh"

module tcb_checker (
  input  logic          man,
  input  logic          reset,
  input  logic          vld,
  input  logic          wen,
  input  tcb_pkg::adr_t adr,
  input  tcb_pkg::ben_t ben,
  input  tcb_pkg::dat_t wdt,
  input  tcb_pkg::dat_t rdt,
  input  logic          err,
  output int            checks,
  output int            errors
);

  import tcb_pkg::*;

  localparam int unsigned MEM_AW = $clog2(`TCB_MEM_BYTES);
  localparam int unsigned OFF_W = $clog2(`TCB_BEW);
  localparam adr_t MEM_LIMIT = adr_t'(`TCB_MEM_BYTES);

  // one transfer as seen on the port plus the word it reads
  typedef struct packed {
    logic vld;
    logic wen;
    adr_t adr;
    ben_t ben;
    dat_t word;
  } xfer_t;

  ////////////////////
  // model state
  ////////////////////

  logic [7:0] ref_mem [`TCB_MEM_BYTES];
  // transfer sampled on the previous edge
  xfer_t p1;
  dat_t exp_rdt;
  logic exp_err;
  int n_checks = 0;
  int n_errors = 0;

  assign checks = n_checks;
  assign errors = n_errors;

  // aligned word from the model memory
  function automatic dat_t mem_word(input adr_t a);
    logic [MEM_AW-1:0] idx;
    dat_t w;
    idx = a[MEM_AW-1:0];
    for (int b = 0; b < `TCB_BEW; b++) begin
      idx[OFF_W-1:0] = OFF_W'(b);
      w[8*b +: 8] = ref_mem[idx];
    end
    return w;
  endfunction

  // expected {err, rdt} once a transfer's response lands
  function automatic logic [`TCB_DBW:0] ref_response(input xfer_t x, input dat_t prev_rdt);
    logic hit;
    dat_t nxt;
    hit = (x.adr < MEM_LIMIT);
    nxt = prev_rdt;
    // reads only
    if (x.vld && !x.wen) begin
      for (int b = 0; b < `TCB_BEW; b++) begin
        // bytes not asked for are kept
        if (x.ben[b]) begin
          // out of range reads return zero
          nxt[8*b +: 8] = hit ? x.word[8*b +: 8] : 8'h00;
        end
      end
    end
    return {x.vld && !hit, nxt};
  endfunction

  ////////////////////
  // model update
  ////////////////////

  always @(posedge man) begin : model_step
    xfer_t cur;
    logic [`TCB_DBW:0] resp;
    logic [MEM_AW-1:0] idx;
    if (reset) begin
      exp_rdt = '0;
      exp_err = 1'b0;
      p1 = '0;
    end else begin
      // response of the transfer one edge back
      resp = ref_response(p1, exp_rdt);
      exp_rdt = resp[`TCB_DBW-1:0];
      exp_err = resp[`TCB_DBW];
      // read before this edge's write
      cur.vld = vld;
      cur.wen = wen;
      cur.adr = adr;
      cur.ben = ben;
      // aliased word when out of range, never used then
      cur.word = mem_word(adr);
      p1 = cur;
      if (vld && wen && (adr < MEM_LIMIT)) begin
        idx = adr[MEM_AW-1:0];
        for (int b = 0; b < `TCB_BEW; b++) begin
          if (ben[b]) begin
            idx[OFF_W-1:0] = OFF_W'(b);
            ref_mem[idx] = wdt[8*b +: 8];
          end
        end
      end
    end
  end

  ////////////////////
  // compare
  ////////////////////

  // outputs settled by the falling edge
  always @(negedge man) begin
    if (!reset) begin
      n_checks++;
      if (rdt !== exp_rdt) begin
        n_errors++;
        $display("ERROR %0t: rdt is %h, expected %h", $time, rdt, exp_rdt);
      end
      if (err !== exp_err) begin
        n_errors++;
        $display("ERROR %0t: err is %b, expected %b", $time, err, exp_err);
      end
    end
  end

endmodule

// ==== tb/tcb_assertions.sv ====
`timescale 1ns/1ps

module tcb_assertions (
  input logic          man,
  input logic          reset,
  input logic          err,
  input logic          man_err,
  input tcb_pkg::dat_t rdt,
  input tcb_pkg::ben_t rbe_dly
);

  // number of failed assertions so far
  int fail_count = 0;

  ////////////////////
  // properties
  ////////////////////

  // err clear in the first cycle out of reset
  err_low_after_reset: assert property (@(posedge man) $fell(reset) |=> !err)
    else begin
      fail_count++;
      $error("err high in the first cycle after reset");
    end

  // no read enable lined up, so rdt holds
  rdt_hold: assert property (@(posedge man) disable iff (reset)
    (rbe_dly == '0) |=> $stable(rdt))
    else begin
      fail_count++;
      $error("rdt changed without a delayed read enable");
    end

  // one register stage on the error flag
  err_follow: assert property (@(posedge man) disable iff (reset)
    !reset |=> (err == $past(man_err)))
    else begin
      fail_count++;
      $error("err does not follow man_err one cycle later");
    end

endmodule

// ==== rtl/tcb_subsystem_top.sv ====
`timescale 1ns/1ps

module tcb_subsystem_top (
  input  logic          man,
  input  logic          reset,
  // TCB subordinate port
  input  logic          vld,
  input  logic          wen,
  input  tcb_pkg::adr_t adr,
  input  tcb_pkg::ben_t ben,
  input  tcb_pkg::dat_t wdt,
  // response two cycles after the transfer
  output tcb_pkg::dat_t rdt,
  output logic          err
);

  import tcb_pkg::*;

  ////////////////////
  // slice to memory
  ////////////////////

  // request side
  logic man_vld;
  logic man_wen;
  adr_t man_adr;
  ben_t man_ben;
  dat_t man_wdt;

  // response side, one cycle after the transfer
  dat_t man_rdt;
  logic man_err;

  ////////////////////
  // response slice
  ////////////////////

  // byte granularity hold
  tcb_register_response #(
    .GRN (1)
  ) resp_slice (
    .man     (man),
    .reset   (reset),
    .vld     (vld),
    .wen     (wen),
    .adr     (adr),
    .ben     (ben),
    .wdt     (wdt),
    .rdt     (rdt),
    .err     (err),
    .man_vld (man_vld),
    .man_wen (man_wen),
    .man_adr (man_adr),
    .man_ben (man_ben),
    .man_wdt (man_wdt),
    .man_rdt (man_rdt),
    .man_err (man_err)
  );

  ////////////////////
  // memory
  ////////////////////

  tcb_mem_sub mem_sub (
    .man   (man),
    .reset (reset),
    .vld   (man_vld),
    .wen   (man_wen),
    .adr   (man_adr),
    .ben   (man_ben),
    .wdt   (man_wdt),
    .rdt   (man_rdt),
    .err   (man_err)
  );

endmodule

// ==== rtl/tcb_mem_sub.sv ====
`timescale 1ns/1ps
`include "tcb_defines.svh"

module tcb_mem_sub (
  input  logic          man,
  input  logic          reset,
  // request, always accepted
  input  logic          vld,
  input  logic          wen,
  input  tcb_pkg::adr_t adr,
  input  tcb_pkg::ben_t ben,
  input  tcb_pkg::dat_t wdt,
  // response after TCB_MEM_DLY cycles
  output tcb_pkg::dat_t rdt,
  output logic          err
);

  import tcb_pkg::*;

  // byte index width over the whole array
  localparam int unsigned MEM_AW = $clog2(`TCB_MEM_BYTES);

  // byte offset bits inside one word
  localparam int unsigned OFF_W = $clog2(`TCB_BEW);

  ////////////////////
  // storage
  ////////////////////

  // byte array, contents survive reset
  logic [7:0] mem [`TCB_MEM_BYTES];

  ////////////////////
  // address decode
  ////////////////////

  // transfer hits the array
  logic in_range;

  // word index, low offset bits dropped for alignment
  logic [MEM_AW-OFF_W-1:0] word_idx;

  // transfer qualifiers
  logic wr_en;
  logic rd_en;

  assign in_range = (adr < adr_t'(`TCB_MEM_BYTES));
  assign word_idx = adr[MEM_AW-1:OFF_W];

  // out of range transfers do nothing to the array
  assign wr_en = vld && wen && in_range;
  assign rd_en = vld && !wen && in_range;

  ////////////////////
  // write
  ////////////////////

  // enabled bytes only, at edge N of the transfer
  always_ff @(posedge man) begin
    if (wr_en) begin
      for (int unsigned b = 0; b < `TCB_BEW; b++) begin
        if (ben[b]) begin
          mem[{word_idx, OFF_W'(b)}] <= wdt[8*b +: 8];
        end
      end
    end
  end

  ////////////////////
  // read
  ////////////////////

  // addressed word assembled from the byte array
  dat_t rd_word;

  always_comb begin
    for (int unsigned b = 0; b < `TCB_BEW; b++) begin
      rd_word[8*b +: 8] = mem[{word_idx, OFF_W'(b)}];
    end
  end

  // registered read data
  // zero on writes, idle cycles and out of range reads
  always_ff @(posedge man) begin
    rdt <= rd_en ? rd_word : '0;
  end

  ////////////////////
  // error response
  ////////////////////

  // any transfer outside the array is flagged
  rsp_err_t err_req;

  assign err_req = vld && !in_range;

  // error flag lines up with rdt
  tcb_delay_line #(
    .payload_t (rsp_err_t),
    .DEPTH     (`TCB_MEM_DLY)
  ) err_line (
    .man   (man),
    .reset (reset),
    .din   (err_req),
    .dout  (err)
  );

endmodule

// ==== rtl/tcb_register_response.sv ====
`timescale 1ns/1ps
`include "tcb_defines.svh"

module tcb_register_response #(
  // hold granularity in bytes, 1 2 or 4
  parameter int unsigned GRN = 1
) (
  input  logic          man,
  input  logic          reset,
  // subordinate side, the manager connects here
  input  logic          vld,
  input  logic          wen,
  input  tcb_pkg::adr_t adr,
  input  tcb_pkg::ben_t ben,
  input  tcb_pkg::dat_t wdt,
  output tcb_pkg::dat_t rdt,
  output logic          err,
  // manager side, the memory connects here
  output logic          man_vld,
  output logic          man_wen,
  output tcb_pkg::adr_t man_adr,
  output tcb_pkg::ben_t man_ben,
  output tcb_pkg::dat_t man_wdt,
  input  tcb_pkg::dat_t man_rdt,
  input  logic          man_err
);

  import tcb_pkg::*;

  // number of hold granules in one data word
  localparam int unsigned GRN_CNT = `TCB_BEW / GRN;

  // granule width in bits
  localparam int unsigned GRN_BITS = 8 * GRN;

  ////////////////////
  // request path
  ////////////////////

  // no request register here
  // all fields go straight to the memory
  assign man_vld = vld;
  assign man_wen = wen;
  assign man_adr = adr;
  assign man_ben = ben;
  assign man_wdt = wdt;

  ////////////////////
  // read enable tracking
  ////////////////////

  // bytes that a read transfer asks for
  ben_t rbe;

  // same mask lined up with the memory response
  ben_t rbe_dly;

  // writes and idle cycles return nothing valid
  assign rbe = (vld && !wen) ? ben : '0;

  // delay matches the memory response delay
  tcb_delay_line #(
    .payload_t (ben_t),
    .DEPTH     (`TCB_MEM_DLY)
  ) rbe_line (
    .man   (man),
    .reset (reset),
    .din   (rbe),
    .dout  (rbe_dly)
  );

  ////////////////////
  // response register
  ////////////////////

  // one extra stage on the response
  // granules without a read enable keep their old value
  always_ff @(posedge man) begin
    if (reset) begin
      rdt <= '0;
      err <= 1'b0;
    end else begin
      for (int unsigned g = 0; g < GRN_CNT; g++) begin
        // any enabled byte loads the whole granule
        if (|rbe_dly[g*GRN +: GRN]) begin
          rdt[g*GRN_BITS +: GRN_BITS] <= man_rdt[g*GRN_BITS +: GRN_BITS];
        end
      end
      // error flag follows every cycle
      err <= man_err;
    end
  end

endmodule

// ==== rtl/tcb_delay_line.sv ====
`timescale 1ns/1ps

module tcb_delay_line #(
  // payload carried through the pipeline
  parameter type payload_t = logic,
  // number of register stages, 1 or more
  parameter int unsigned DEPTH = 1
) (
  input  logic     man,
  input  logic     reset,
  input  payload_t din,
  output payload_t dout
);

  ////////////////////
  // pipeline storage
  ////////////////////

  // stage 0 takes din
  // stage DEPTH-1 drives dout
  payload_t stage [DEPTH];

  ////////////////////
  // shift
  ////////////////////

  always_ff @(posedge man) begin
    if (reset) begin
      // all stages empty after reset
      for (int unsigned i = 0; i < DEPTH; i++) begin
        stage[i] <= '0;
      end
    end else begin
      // new entry
      stage[0] <= din;
      // move older entries one stage on
      for (int unsigned i = 1; i < DEPTH; i++) begin
        stage[i] <= stage[i-1];
      end
    end
  end

  ////////////////////
  // output
  ////////////////////

  // oldest entry
  assign dout = stage[DEPTH-1];

endmodule

// ==== rtl/tcb_pkg.sv ====
`include "tcb_defines.svh"

package tcb_pkg;

  ////////////////////
  // request fields
  ////////////////////

  // byte address
  typedef logic [`TCB_ABW-1:0] adr_t;

  // write data, also used for read data
  typedef logic [`TCB_DBW-1:0] dat_t;

  // byte enables
  // bit i covers data bits [8*i+7:8*i]
  typedef logic [`TCB_BEW-1:0] ben_t;

  ////////////////////
  // response fields
  ////////////////////

  // single bit error flag
  // named type so a delay line can carry it
  typedef logic rsp_err_t;

endpackage

// ==== include/tcb_defines.svh ====
`ifndef TCB_DEFINES_SVH
`define TCB_DEFINES_SVH

////////////////////
// bus widths
////////////////////

// address width in bits
`define TCB_ABW 32

// data width in bits
`define TCB_DBW 32

// one enable per data byte
`define TCB_BEW (`TCB_DBW/8)

////////////////////
// memory subordinate
////////////////////

// memory size in bytes
// addresses at or above this answer with err
`define TCB_MEM_BYTES 1024

// response delay of the memory in cycles
// top level delay is one more for the slice
`define TCB_MEM_DLY 1

`endif
